//--- acc/cmux_acc.sv
/*
  CMUX accumulator
  Takes a command over req/ack, claims the GRAM window, pairs each buffered
  multiplier beat with a GRAM read, adds lane by lane mod Q and writes back
  Done pulse carries the pbs id, stream errors kept in a sticky register
*/
`timescale 1ns/1ps
`include "mmacc_consts.svh"

module cmux_acc #(
  parameter int RD_LATENCY = `GRAM_RD_LAT,
  parameter int FIFO_DEPTH = `NTT_FIFO_DEPTH
) (
  input  logic                    clk,
  input  logic                    s_rst_n,
  input  mmacc_pkg::acc_cmd_t     cmd,
  input  logic                    cmd_req,
  output logic                    cmd_ack,
  input  logic                    ntt_avail,
  input  mmacc_pkg::ntt_beat_t    ntt_beat,
  output mmacc_pkg::garb_req_t    acc_garb_req,
  output logic                    acc_garb_req_vld,
  input  logic                    acc_garb_req_rdy,
  output logic                    acc_garb_release,
  output logic                    rd_en,
  output logic [`GRAM_ADDR_W-1:0] rd_addr,
  input  mmacc_pkg::coef_vec_t    rd_data,
  input  logic                    rd_avail,
  output logic                    wr_en,
  output logic [`GRAM_ADDR_W-1:0] wr_addr,
  output mmacc_pkg::coef_vec_t    wr_data,
  output logic                    acc_feed_done,
  output logic [`PBS_ID_W-1:0]    acc_feed_done_pbs_id,
  output mmacc_pkg::acc_error_t   error
);

  typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_RUN, ST_DRAIN} state_t;

  state_t                 state;
  state_t                 state_n;
  mmacc_pkg::acc_cmd_t    cmd_r;
  logic                   cmd_latch;
  logic [`NB_BEATS_W-1:0] issue_cnt;
  logic                   issue_last;
  mmacc_pkg::ntt_beat_t   beat_head;
  logic                   beat_empty;
  logic                   beat_full;
  mmacc_pkg::rd_tag_t     tag_in;
  mmacc_pkg::rd_tag_t     tag_head;
  logic                   tag_empty;
  mmacc_pkg::coef_vec_t   sum;
  logic                   wr_last;
  mmacc_pkg::acc_error_t  err_det;

  // One conditional subtraction, both inputs below Q
  function automatic logic [`MOD_Q_W-1:0] mod_add(input logic [`MOD_Q_W-1:0] a,
                                                  input logic [`MOD_Q_W-1:0] b);
    logic [`MOD_Q_W:0] s;
    s = a + b;
    if (s >= `MOD_Q) s = s - `MOD_Q;
    return s[`MOD_Q_W-1:0];
  endfunction

  // ==========================================================
  // Command intake and FSM
  // ==========================================================
  // Ack still high means the last req has not dropped yet
  assign cmd_latch  = (state == ST_IDLE) && cmd_req && !cmd_ack;
  assign issue_last = (issue_cnt == cmd_r.nb_beats);

  assign acc_garb_req_vld        = (state == ST_REQ);
  assign acc_garb_req.start_addr = cmd_r.base_addr;
  assign acc_garb_req.len        = cmd_r.nb_beats;

  always_comb begin
    state_n = state;
    case (state)
      ST_IDLE:  if (cmd_latch)              state_n = ST_REQ;
      ST_REQ:   if (acc_garb_req_rdy)       state_n = ST_RUN;
      ST_RUN:   if (rd_en && issue_last)    state_n = ST_DRAIN;
      ST_DRAIN: if (wr_en && wr_last)       state_n = ST_IDLE;
      default:                              state_n = ST_IDLE;
    endcase
  end

  // ==========================================================
  // Read issue, one beat per read
  // ==========================================================
  assign rd_en   = (state == ST_RUN) && !beat_empty;
  assign rd_addr = cmd_r.base_addr + `GRAM_ADDR_W'(issue_cnt);

  assign tag_in.wr_addr = rd_addr;
  assign tag_in.data    = beat_head.data;
  assign tag_in.last    = issue_last;

  // Beats may land before the command
  sync_fifo #(
    .payload_t (mmacc_pkg::ntt_beat_t),
    .DEPTH     (FIFO_DEPTH)
  ) beat_fifo (
    .clk       (clk),
    .s_rst_n   (s_rst_n),
    .push      (ntt_avail),
    .push_data (ntt_beat),
    .pop       (rd_en),
    .pop_data  (beat_head),
    .empty     (beat_empty),
    .full      (beat_full)
  );

  // At most RD_LATENCY reads wait for data
  sync_fifo #(
    .payload_t (mmacc_pkg::rd_tag_t),
    .DEPTH     (RD_LATENCY + 1)
  ) tag_fifo (
    .clk       (clk),
    .s_rst_n   (s_rst_n),
    .push      (rd_en),
    .push_data (tag_in),
    .pop       (rd_avail),
    .pop_data  (tag_head),
    .empty     (tag_empty),
    .full      ()
  );

  // ==========================================================
  // Modular add and checks
  // ==========================================================
  always_comb begin
    for (int i = 0; i < `ACC_LANES; i++) begin
      sum[i] = mod_add(rd_data[i], tag_head.data[i]);
    end
  end

  // Frame flags checked against the beat's slot in the command
  always_comb begin
    err_det           = '0;
    err_det.ntt_ovf   = ntt_avail && beat_full;
    err_det.frame_err = rd_en && ((beat_head.sob != (issue_cnt == '0)) ||
                                  (beat_head.eob != issue_last) ||
                                  (beat_head.pbs_id != cmd_r.pbs_id));
  end

  assign acc_garb_release = acc_feed_done;

  // Payload registers
  always_ff @(posedge clk) begin
    if (cmd_latch) cmd_r <= cmd;
    if (rd_avail) begin
      wr_addr <= tag_head.wr_addr;
      wr_data <= sum;
      wr_last <= tag_head.last;
    end
    if (wr_en && wr_last) acc_feed_done_pbs_id <= cmd_r.pbs_id;
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      state         <= ST_IDLE;
      cmd_ack       <= 1'b0;
      issue_cnt     <= '0;
      wr_en         <= 1'b0;
      acc_feed_done <= 1'b0;
      error         <= '0;
    end else begin
      state <= state_n;
      // Ack falls the cycle after req falls
      if (cmd_latch)     cmd_ack <= 1'b1;
      else if (!cmd_req) cmd_ack <= 1'b0;
      if (cmd_latch)  issue_cnt <= '0;
      else if (rd_en) issue_cnt <= issue_cnt + 1'b1;
      // Stray return with no tag is ignored
      wr_en         <= rd_avail && !tag_empty;
      acc_feed_done <= wr_en && wr_last;
      error         <= error | err_det;
    end
  end

endmodule

//--- common/mmacc_consts.svh
/*
  MMACC constants
  Modulus, widths, lane count and default depths of the CMUX accumulate step
*/
`ifndef MMACC_CONSTS_SVH
`define MMACC_CONSTS_SVH

// Prime modulus, just below 2^16
`define MOD_Q          65521
`define MOD_Q_W        16
// Coefficients per beat and per GRAM word
`define ACC_LANES      4
`define GRAM_ADDR_W    6
`define PBS_ID_W       4
// Beat count is stored as count minus one
`define NB_BEATS_W     6
`define GRAM_RD_LAT    2
`define NTT_FIFO_DEPTH 16

`endif

//--- common/mmacc_pkg.sv
/*
  MMACC package
  Command, beat, arbiter request, read tag and error types
*/
`include "mmacc_consts.svh"

package mmacc_pkg;

  // One GRAM word, lane 0 in the low bits
  typedef logic [`ACC_LANES-1:0][`MOD_Q_W-1:0] coef_vec_t;

  typedef struct packed {
    logic [`GRAM_ADDR_W-1:0] base_addr;
    logic [`NB_BEATS_W-1:0]  nb_beats;   // count minus one
    logic [`PBS_ID_W-1:0]    pbs_id;
  } acc_cmd_t;

  // Multiplier result beat
  typedef struct packed {
    coef_vec_t               data;
    logic                    sob;
    logic                    eob;
    logic [`PBS_ID_W-1:0]    pbs_id;
  } ntt_beat_t;

  typedef struct packed {
    logic [`GRAM_ADDR_W-1:0] start_addr;
    logic [`NB_BEATS_W-1:0]  len;        // count minus one
  } garb_req_t;

  // Read in flight, paired with its beat
  typedef struct packed {
    logic [`GRAM_ADDR_W-1:0] wr_addr;
    coef_vec_t               data;
    logic                    last;
  } rd_tag_t;

  typedef struct packed {
    logic ntt_ovf;
    logic frame_err;
  } acc_error_t;

endpackage

//--- logic/glwe_ram.sv
/*
  GLWE RAM
  One write port and one read port, data back RD_LATENCY cycles after rd_en
  Read and write to one address in a cycle returns the old word
*/
`timescale 1ns/1ps
`include "mmacc_consts.svh"

module glwe_ram #(
  parameter int RD_LATENCY = `GRAM_RD_LAT
) (
  input  logic                    clk,
  input  logic                    s_rst_n,
  input  logic                    rd_en,
  input  logic [`GRAM_ADDR_W-1:0] rd_addr,
  output mmacc_pkg::coef_vec_t    rd_data,
  output logic                    rd_avail,
  input  logic                    wr_en,
  input  logic [`GRAM_ADDR_W-1:0] wr_addr,
  input  mmacc_pkg::coef_vec_t    wr_data
);

  mmacc_pkg::coef_vec_t  mem [2**`GRAM_ADDR_W];
  mmacc_pkg::coef_vec_t  data_pipe [RD_LATENCY];
  logic [RD_LATENCY-1:0] avail_pipe;

  // Array and data stages carry no reset
  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_addr] <= wr_data;
    // Old content sampled before the write lands
    if (rd_en) data_pipe[0] <= mem[rd_addr];
    for (int i = 1; i < RD_LATENCY; i++) begin
      data_pipe[i] <= data_pipe[i-1];
    end
  end

  // Valid flag follows the data stages
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      avail_pipe <= '0;
    end else begin
      avail_pipe[0] <= rd_en;
      for (int i = 1; i < RD_LATENCY; i++) begin
        avail_pipe[i] <= avail_pipe[i-1];
      end
    end
  end

  assign rd_data  = data_pipe[RD_LATENCY-1];
  assign rd_avail = avail_pipe[RD_LATENCY-1];

endmodule

//--- logic/gram_arbiter.sv
/*
  GRAM arbiter
  Host port owns the RAM by default, accumulator owns it between grant and release
  Read returns are steered back to whichever side issued them
*/
`timescale 1ns/1ps
`include "mmacc_consts.svh"

module gram_arbiter #(
  parameter int RD_LATENCY = `GRAM_RD_LAT
) (
  input  logic                    clk,
  input  logic                    s_rst_n,
  // Host port
  input  logic                    host_wr_en,
  input  logic [`GRAM_ADDR_W-1:0] host_wr_addr,
  input  mmacc_pkg::coef_vec_t    host_wr_data,
  input  logic                    host_rd_en,
  input  logic [`GRAM_ADDR_W-1:0] host_rd_addr,
  output mmacc_pkg::coef_vec_t    host_rd_data,
  output logic                    host_rd_avail,
  // Accumulator batch request
  input  mmacc_pkg::garb_req_t    acc_garb_req,
  input  logic                    acc_garb_req_vld,
  output logic                    acc_garb_req_rdy,
  input  logic                    acc_garb_release,
  // Accumulator RAM side
  input  logic                    acc_rd_en,
  input  logic [`GRAM_ADDR_W-1:0] acc_rd_addr,
  output logic                    acc_rd_avail,
  input  logic                    acc_wr_en,
  input  logic [`GRAM_ADDR_W-1:0] acc_wr_addr,
  input  mmacc_pkg::coef_vec_t    acc_wr_data,
  output logic                    gram_busy,
  // RAM ports
  output logic                    rd_en,
  output logic [`GRAM_ADDR_W-1:0] rd_addr,
  output logic                    wr_en,
  output logic [`GRAM_ADDR_W-1:0] wr_addr,
  output mmacc_pkg::coef_vec_t    wr_data,
  input  mmacc_pkg::coef_vec_t    rd_data,
  input  logic                    rd_avail
);

  logic                    grant;
  mmacc_pkg::garb_req_t    win;
  logic [RD_LATENCY-1:0]   acc_own;
  logic [`GRAM_ADDR_W-1:0] rd_ofs;
  logic [`GRAM_ADDR_W-1:0] wr_ofs;
  logic                    acc_rd_ok;
  logic                    acc_wr_ok;

  // No grant while the host is mid-access
  assign acc_garb_req_rdy = !grant && !host_wr_en && !host_rd_en;
  assign gram_busy        = grant;

  // Accumulator accesses confined to the granted window
  assign rd_ofs    = acc_rd_addr - win.start_addr;
  assign wr_ofs    = acc_wr_addr - win.start_addr;
  assign acc_rd_ok = acc_rd_en && (rd_ofs <= win.len);
  assign acc_wr_ok = acc_wr_en && (wr_ofs <= win.len);

  // ==========================================================
  // RAM steering
  // ==========================================================
  assign rd_en   = grant ? acc_rd_ok   : host_rd_en;
  assign rd_addr = grant ? acc_rd_addr : host_rd_addr;
  assign wr_en   = grant ? acc_wr_ok   : host_wr_en;
  assign wr_addr = grant ? acc_wr_addr : host_wr_addr;
  assign wr_data = grant ? acc_wr_data : host_wr_data;

  // Oldest owner bit lines up with the returning word
  assign acc_rd_avail  = rd_avail && acc_own[RD_LATENCY-1];
  assign host_rd_avail = rd_avail && !acc_own[RD_LATENCY-1];
  assign host_rd_data  = rd_data;

  always_ff @(posedge clk) begin
    if (acc_garb_req_vld && acc_garb_req_rdy) win <= acc_garb_req;
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      grant   <= 1'b0;
      acc_own <= '0;
    end else begin
      if (acc_garb_req_vld && acc_garb_req_rdy) grant <= 1'b1;
      else if (acc_garb_release)                grant <= 1'b0;
      acc_own[0] <= grant && acc_rd_ok;
      for (int i = 1; i < RD_LATENCY; i++) begin
        acc_own[i] <= acc_own[i-1];
      end
    end
  end

endmodule

//--- logic/mmacc_top.sv
/*
  MMACC top
  Accumulator, GRAM arbiter and GLWE RAM
*/
`timescale 1ns/1ps
`include "mmacc_consts.svh"

module mmacc_top #(
  parameter int RD_LATENCY = `GRAM_RD_LAT,
  parameter int FIFO_DEPTH = `NTT_FIFO_DEPTH
) (
  input  logic                    clk,
  input  logic                    s_rst_n,
  input  mmacc_pkg::acc_cmd_t     cmd,
  input  logic                    cmd_req,
  output logic                    cmd_ack,
  input  logic                    ntt_avail,
  input  mmacc_pkg::ntt_beat_t    ntt_beat,
  input  logic                    host_wr_en,
  input  logic [`GRAM_ADDR_W-1:0] host_wr_addr,
  input  mmacc_pkg::coef_vec_t    host_wr_data,
  input  logic                    host_rd_en,
  input  logic [`GRAM_ADDR_W-1:0] host_rd_addr,
  output mmacc_pkg::coef_vec_t    host_rd_data,
  output logic                    host_rd_avail,
  output logic                    gram_busy,
  output logic                    acc_feed_done,
  output logic [`PBS_ID_W-1:0]    acc_feed_done_pbs_id,
  output mmacc_pkg::acc_error_t   error
);

  // Accumulator to arbiter
  mmacc_pkg::garb_req_t    acc_garb_req;
  logic                    acc_garb_req_vld;
  logic                    acc_garb_req_rdy;
  logic                    acc_garb_release;
  logic                    acc_rd_en;
  logic [`GRAM_ADDR_W-1:0] acc_rd_addr;
  logic                    acc_rd_avail;
  logic                    acc_wr_en;
  logic [`GRAM_ADDR_W-1:0] acc_wr_addr;
  mmacc_pkg::coef_vec_t    acc_wr_data;
  // Arbiter to RAM
  logic                    rd_en;
  logic [`GRAM_ADDR_W-1:0] rd_addr;
  mmacc_pkg::coef_vec_t    rd_data;
  logic                    rd_avail;
  logic                    wr_en;
  logic [`GRAM_ADDR_W-1:0] wr_addr;
  mmacc_pkg::coef_vec_t    wr_data;

  cmux_acc #(
    .RD_LATENCY (RD_LATENCY),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) cmux_acc0 (
    .clk                  (clk),
    .s_rst_n              (s_rst_n),
    .cmd                  (cmd),
    .cmd_req              (cmd_req),
    .cmd_ack              (cmd_ack),
    .ntt_avail            (ntt_avail),
    .ntt_beat             (ntt_beat),
    .acc_garb_req         (acc_garb_req),
    .acc_garb_req_vld     (acc_garb_req_vld),
    .acc_garb_req_rdy     (acc_garb_req_rdy),
    .acc_garb_release     (acc_garb_release),
    .rd_en                (acc_rd_en),
    .rd_addr              (acc_rd_addr),
    .rd_data              (rd_data),
    .rd_avail             (acc_rd_avail),
    .wr_en                (acc_wr_en),
    .wr_addr              (acc_wr_addr),
    .wr_data              (acc_wr_data),
    .acc_feed_done        (acc_feed_done),
    .acc_feed_done_pbs_id (acc_feed_done_pbs_id),
    .error                (error)
  );

  gram_arbiter #(
    .RD_LATENCY (RD_LATENCY)
  ) gram_arbiter0 (
    .clk              (clk),
    .s_rst_n          (s_rst_n),
    .host_wr_en       (host_wr_en),
    .host_wr_addr     (host_wr_addr),
    .host_wr_data     (host_wr_data),
    .host_rd_en       (host_rd_en),
    .host_rd_addr     (host_rd_addr),
    .host_rd_data     (host_rd_data),
    .host_rd_avail    (host_rd_avail),
    .acc_garb_req     (acc_garb_req),
    .acc_garb_req_vld (acc_garb_req_vld),
    .acc_garb_req_rdy (acc_garb_req_rdy),
    .acc_garb_release (acc_garb_release),
    .acc_rd_en        (acc_rd_en),
    .acc_rd_addr      (acc_rd_addr),
    .acc_rd_avail     (acc_rd_avail),
    .acc_wr_en        (acc_wr_en),
    .acc_wr_addr      (acc_wr_addr),
    .acc_wr_data      (acc_wr_data),
    .gram_busy        (gram_busy),
    .rd_en            (rd_en),
    .rd_addr          (rd_addr),
    .wr_en            (wr_en),
    .wr_addr          (wr_addr),
    .wr_data          (wr_data),
    .rd_data          (rd_data),
    .rd_avail         (rd_avail)
  );

  glwe_ram #(
    .RD_LATENCY (RD_LATENCY)
  ) glwe_ram0 (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .rd_avail (rd_avail),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

endmodule

//--- logic/sync_fifo.sv
/*
  Synchronous FIFO
  First-word-fall-through, payload given as a type parameter
  Push while full is dropped, the owner flags it
*/
`timescale 1ns/1ps

module sync_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 16
) (
  input  logic     clk,
  input  logic     s_rst_n,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty,
  output logic     full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_push;
  logic             do_pop;

  assign empty    = (count == '0);
  assign full     = (count == (PTR_W+1)'(DEPTH));
  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;
  // Head word visible without a pop
  assign pop_data = mem[rd_ptr];

  // Storage, no reset
  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap at DEPTH, not only at powers of 2
      if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- mmacc_top.f
+incdir+common
common/mmacc_pkg.sv
logic/sync_fifo.sv
logic/glwe_ram.sv
logic/gram_arbiter.sv
acc/cmux_acc.sv
logic/mmacc_top.sv
testbench/tb_checker.sv
testbench/tb_mmacc.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the MMACC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_mmacc -f mmacc_top.f -o tb_mmacc > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_mmacc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

//--- testbench/tb_checker.sv
/*
  Testbench checker
  Watches the DUT ports, compares read-back words, done pulses and the error
  register with expected values from the testbench, and counts mismatches
*/
`timescale 1ns/1ps
`include "mmacc_consts.svh"

module tb_checker (
  input  logic                    clk,
  input  logic                    s_rst_n,
  input  logic                    cmd_req,
  input  logic                    cmd_ack,
  input  logic                    gram_busy,
  input  logic                    acc_feed_done,
  input  logic [`PBS_ID_W-1:0]    acc_feed_done_pbs_id,
  input  mmacc_pkg::acc_error_t   error,
  input  logic                    host_rd_en,
  input  logic                    host_rd_avail,
  input  mmacc_pkg::coef_vec_t    host_rd_data,
  input  mmacc_pkg::coef_vec_t    exp_word,
  input  logic [`PBS_ID_W-1:0]    exp_pbs_id,
  input  mmacc_pkg::acc_error_t   exp_error,
  output int                      err_cnt,
  output int                      pending
);

  mmacc_pkg::coef_vec_t  exp_mem [64];
  int                    push_cnt = 0;
  int                    pop_cnt = 0;
  int                    errs = 0;
  int                    rst_edges = 0;
  int                    acc_cnt = 0;
  int                    done_cnt = 0;
  logic                  prev_req = 1'b0;
  logic                  prev_ack = 1'b0;
  logic                  prev_done = 1'b0;
  logic                  in_cmd = 1'b0;
  logic                  busy_seen = 1'b0;
  mmacc_pkg::acc_error_t prev_err = '0;

  assign err_cnt = errs;
  assign pending = push_cnt - pop_cnt;

  // Expected words queued in host read order
  always @(posedge clk) begin
    if (!s_rst_n) rst_edges <= rst_edges + 1;
    if (s_rst_n && host_rd_en) begin
      exp_mem[push_cnt % 64] <= exp_word;
      push_cnt               <= push_cnt + 1;
    end
  end

  // ==========================================================
  // Output checks, sampled mid-cycle
  // ==========================================================
  always @(negedge clk) begin
    if (!s_rst_n) begin
      if (rst_edges > 0 && (cmd_ack || gram_busy || acc_feed_done || error != '0)) begin
        $display("error: cmd_ack=0x%h gram_busy=0x%h acc_feed_done=0x%h error=0x%h in reset",
                 cmd_ack, gram_busy, acc_feed_done, error);
        errs = errs + 1;
      end
    end else begin
      // Four-phase command port
      if (cmd_ack && !prev_ack && !prev_req) begin
        $display("cmd_ack rose with no cmd_req pending");
        errs = errs + 1;
      end
      if (cmd_ack && !cmd_req && !prev_req) begin
        $display("cmd_ack still high a cycle after cmd_req fell");
        errs = errs + 1;
      end
      if (!cmd_ack && prev_ack && prev_req) begin
        $display("cmd_ack fell while cmd_req was still high");
        errs = errs + 1;
      end
      if (cmd_ack && !prev_ack) begin
        if (acc_cnt != done_cnt) begin
          $display("Command accepted before the previous one finished");
          errs = errs + 1;
        end
        acc_cnt   = acc_cnt + 1;
        in_cmd    = 1'b1;
        busy_seen = 1'b0;
      end
      // Grant window
      if (in_cmd && gram_busy) busy_seen = 1'b1;
      if (in_cmd && busy_seen && !gram_busy) begin
        $display("gram_busy dropped before acc_feed_done");
        errs = errs + 1;
      end
      if (!in_cmd && gram_busy) begin
        $display("gram_busy high with no command in progress");
        errs = errs + 1;
      end
      if (acc_feed_done && prev_done) begin
        $display("acc_feed_done held for more than one cycle");
        errs = errs + 1;
      end else if (acc_feed_done) begin
        if (done_cnt >= acc_cnt) begin
          $display("acc_feed_done with no accepted command");
          errs = errs + 1;
        end
        if (acc_feed_done_pbs_id != exp_pbs_id) begin
          $display("error: acc_feed_done_pbs_id = 0x%h, expected 0x%h",
                   acc_feed_done_pbs_id, exp_pbs_id);
          errs = errs + 1;
        end
        if (error != exp_error) begin
          $display("error: error = 0x%h, expected 0x%h", error, exp_error);
          errs = errs + 1;
        end
        done_cnt = done_cnt + 1;
        in_cmd   = 1'b0;
      end
      // Error flags are sticky
      if ((prev_err & ~error) != '0) begin
        $display("A set error flag was cleared without reset");
        errs = errs + 1;
      end
      // Host read returns
      if (host_rd_avail && pop_cnt >= push_cnt) begin
        $display("Host read data returned with no host read pending");
        errs = errs + 1;
      end else if (host_rd_avail) begin
        if (host_rd_data != exp_mem[pop_cnt % 64]) begin
          $display("error: host_rd_data = 0x%h, expected 0x%h",
                   host_rd_data, exp_mem[pop_cnt % 64]);
          errs = errs + 1;
        end
        pop_cnt = pop_cnt + 1;
      end
    end
    prev_req  = cmd_req;
    prev_ack  = cmd_ack;
    prev_done = acc_feed_done;
    prev_err  = error;
  end

endmodule

//--- testbench/tb_mmacc.sv
/*
  MMACC testbench
  Loads GRAM words over the host port, streams multiplier beats, issues
  accumulate commands from a table and reads the results back
*/
`timescale 1ns/1ps
`include "mmacc_consts.svh"

module tb_mmacc;

  localparam int NUM_ROWS    = 5;
  localparam int CYCLE_LIMIT = 200 * NUM_ROWS + 100;
  localparam int MEM_WORDS   = 2**`GRAM_ADDR_W;

  // One test per row
  typedef struct packed {
    logic [`GRAM_ADDR_W-1:0] base;
    logic [6:0]              nb;          // beat count
    logic [`PBS_ID_W-1:0]    pbs_id;
    logic                    before_cmd;
    logic                    frame_inj;
    mmacc_pkg::acc_error_t   exp_err;
  } test_row_t;

  logic                    clk = 1'b0;
  logic                    s_rst_n;
  mmacc_pkg::acc_cmd_t     cmd;
  logic                    cmd_req;
  logic                    cmd_ack;
  logic                    ntt_avail;
  mmacc_pkg::ntt_beat_t    ntt_beat;
  logic                    host_wr_en;
  logic [`GRAM_ADDR_W-1:0] host_wr_addr;
  mmacc_pkg::coef_vec_t    host_wr_data;
  logic                    host_rd_en;
  logic [`GRAM_ADDR_W-1:0] host_rd_addr;
  mmacc_pkg::coef_vec_t    host_rd_data;
  logic                    host_rd_avail;
  logic                    gram_busy;
  logic                    acc_feed_done;
  logic [`PBS_ID_W-1:0]    acc_feed_done_pbs_id;
  mmacc_pkg::acc_error_t   error;
  mmacc_pkg::coef_vec_t    exp_word;
  logic [`PBS_ID_W-1:0]    exp_pbs_id;
  mmacc_pkg::acc_error_t   exp_error;
  int                      err_cnt;
  int                      pending;
  int                      cycle_cnt = 0;
  int                      seed_val;
  test_row_t               rows [NUM_ROWS];
  mmacc_pkg::coef_vec_t    model [MEM_WORDS];

  mmacc_top dut0 (
    .clk (clk), .s_rst_n (s_rst_n), .cmd (cmd), .cmd_req (cmd_req), .cmd_ack (cmd_ack),
    .ntt_avail (ntt_avail), .ntt_beat (ntt_beat),
    .host_wr_en (host_wr_en), .host_wr_addr (host_wr_addr), .host_wr_data (host_wr_data),
    .host_rd_en (host_rd_en), .host_rd_addr (host_rd_addr), .host_rd_data (host_rd_data),
    .host_rd_avail (host_rd_avail), .gram_busy (gram_busy), .acc_feed_done (acc_feed_done),
    .acc_feed_done_pbs_id (acc_feed_done_pbs_id), .error (error)
  );

  tb_checker chk0 (
    .clk (clk), .s_rst_n (s_rst_n), .cmd_req (cmd_req), .cmd_ack (cmd_ack),
    .gram_busy (gram_busy), .acc_feed_done (acc_feed_done),
    .acc_feed_done_pbs_id (acc_feed_done_pbs_id), .error (error),
    .host_rd_en (host_rd_en), .host_rd_avail (host_rd_avail), .host_rd_data (host_rd_data),
    .exp_word (exp_word), .exp_pbs_id (exp_pbs_id), .exp_error (exp_error),
    .err_cnt (err_cnt), .pending (pending)
  );

  always #20 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, done pulse or read data never came", cycle_cnt);
      $display("Testbench failed");
      $finish;
    end
  end

  // Half the draws land just below Q to force wrap-around
  function automatic logic [`MOD_Q_W-1:0] rand_coef();
    logic [31:0] r;
    r = $urandom;
    if (r[0]) return `MOD_Q_W'(`MOD_Q - 1 - int'(r[8:1] % 16));
    return `MOD_Q_W'(r[31:8] % `MOD_Q);
  endfunction

  function automatic mmacc_pkg::coef_vec_t rand_vec();
    mmacc_pkg::coef_vec_t v;
    for (int i = 0; i < `ACC_LANES; i++) v[i] = rand_coef();
    return v;
  endfunction

  // Reference sum, (a + b) mod Q per lane
  function automatic mmacc_pkg::coef_vec_t add_mod_q(input mmacc_pkg::coef_vec_t a,
                                                     input mmacc_pkg::coef_vec_t b);
    mmacc_pkg::coef_vec_t r;
    int                   s;
    for (int i = 0; i < `ACC_LANES; i++) begin
      s    = int'(a[i]) + int'(b[i]);
      r[i] = `MOD_Q_W'(s % `MOD_Q);
    end
    return r;
  endfunction

  // ==========================================================
  // Host port and stream drivers
  // ==========================================================
  task automatic write_word(input logic [`GRAM_ADDR_W-1:0] a, input mmacc_pkg::coef_vec_t d);
    @(posedge clk);
    #2;
    host_wr_en   = 1'b1;
    host_wr_addr = a;
    host_wr_data = d;
  endtask

  task automatic release_host();
    @(posedge clk);
    #2;
    host_wr_en = 1'b0;
    host_rd_en = 1'b0;
  endtask

  task automatic send_beats(input test_row_t row);
    logic [`GRAM_ADDR_W-1:0] a;
    mmacc_pkg::coef_vec_t    bvec;
    for (int i = 0; i < int'(row.nb); i++) begin
      a        = row.base + `GRAM_ADDR_W'(i);
      bvec     = rand_vec();
      model[a] = add_mod_q(model[a], bvec);
      @(posedge clk);
      #2;
      ntt_avail       = 1'b1;
      ntt_beat.data   = bvec;
      ntt_beat.sob    = (i == 0);
      // Early eob on beat 1 when injecting a frame error
      ntt_beat.eob    = (i == int'(row.nb) - 1) || (row.frame_inj && i == 1);
      ntt_beat.pbs_id = row.pbs_id;
    end
    @(posedge clk);
    #2;
    ntt_avail = 1'b0;
  endtask

  task automatic send_cmd(input test_row_t row);
    @(negedge clk);
    while (cmd_ack) @(negedge clk);
    @(posedge clk);
    #2;
    cmd.base_addr = row.base;
    cmd.nb_beats  = `NB_BEATS_W'(row.nb - 7'd1);
    cmd.pbs_id    = row.pbs_id;
    cmd_req       = 1'b1;
    @(negedge clk);
    while (!cmd_ack) @(negedge clk);
    @(posedge clk);
    #2;
    cmd_req = 1'b0;
  endtask

  // Host write inside the grant to the word just past the range
  // Never rewritten by the accumulator, so it must keep the model value
  task automatic blocked_write(input test_row_t row);
    @(negedge clk);
    while (!gram_busy) @(negedge clk);
    write_word(row.base + `GRAM_ADDR_W'(row.nb), rand_vec());
    release_host();
  endtask

  task automatic read_back(input test_row_t row);
    logic [`GRAM_ADDR_W-1:0] a;
    for (int k = -2; k < int'(row.nb) + 2; k++) begin
      a = row.base + `GRAM_ADDR_W'(k);
      @(posedge clk);
      #2;
      host_rd_en   = 1'b1;
      host_rd_addr = a;
      exp_word     = model[a];
    end
    release_host();
    @(posedge clk);
    while (pending != 0) @(posedge clk);
  endtask

  // ==========================================================
  // Main sequence
  // ==========================================================
  initial begin
    s_rst_n      = 1'b0;
    cmd          = '0;
    cmd_req      = 1'b0;
    ntt_avail    = 1'b0;
    ntt_beat     = '0;
    host_wr_en   = 1'b0;
    host_wr_addr = '0;
    host_wr_data = '0;
    host_rd_en   = 1'b0;
    host_rd_addr = '0;
    exp_word     = '0;
    exp_pbs_id   = '0;
    exp_error    = '0;
    seed_val     = $urandom(50612);
    // base, beats, pbs id, beats first, frame error, expected error
    rows[0] = '{base: 6'd4,  nb: 7'd4, pbs_id: 4'd1, before_cmd: 1'b0, frame_inj: 1'b0,
                exp_err: 2'b00};
    rows[1] = '{base: 6'd20, nb: 7'd8, pbs_id: 4'd2, before_cmd: 1'b1, frame_inj: 1'b0,
                exp_err: 2'b00};
    rows[2] = '{base: 6'd60, nb: 7'd6, pbs_id: 4'd3, before_cmd: 1'b0, frame_inj: 1'b0,
                exp_err: 2'b00};
    rows[3] = '{base: 6'd33, nb: 7'd3, pbs_id: 4'd4, before_cmd: 1'b1, frame_inj: 1'b0,
                exp_err: 2'b00};
    // Sticky frame error, so last
    rows[4] = '{base: 6'd40, nb: 7'd4, pbs_id: 4'd5, before_cmd: 1'b0, frame_inj: 1'b1,
                exp_err: 2'b01};
    repeat (5) @(posedge clk);
    #2;
    s_rst_n = 1'b1;
    for (int a = 0; a < MEM_WORDS; a++) begin
      model[a] = rand_vec();
      write_word(`GRAM_ADDR_W'(a), model[a]);
    end
    release_host();
    for (int r = 0; r < NUM_ROWS; r++) begin
      exp_pbs_id = rows[r].pbs_id;
      exp_error  = rows[r].exp_err;
      for (int i = 0; i < int'(rows[r].nb); i++) begin
        model[rows[r].base + `GRAM_ADDR_W'(i)] = rand_vec();
        write_word(rows[r].base + `GRAM_ADDR_W'(i), model[rows[r].base + `GRAM_ADDR_W'(i)]);
      end
      release_host();
      if (rows[r].before_cmd) begin
        send_beats(rows[r]);
        send_cmd(rows[r]);
        blocked_write(rows[r]);
      end else begin
        send_cmd(rows[r]);
        blocked_write(rows[r]);
        send_beats(rows[r]);
      end
      @(negedge clk);
      while (!acc_feed_done) @(negedge clk);
      read_back(rows[r]);
    end
    repeat (4) @(posedge clk);
    $display("Checks done, %0d errors", err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
